// ==== Makefile ====
SRCS := $(shell cat files.f)

.PHONY: run clean

obj_dir/Vdispatch_stage_tb: $(SRCS) files.f
	verilator --binary --timing --assert --top-module dispatch_stage_tb -f files.f

run: obj_dir/Vdispatch_stage_tb dv/dispatch_stimulus.txt
	./obj_dir/Vdispatch_stage_tb | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== dv/dispatch_stage_checker.sv ====
`timescale 1ns/1ps

module dispatch_stage_checker (
    input logic                                 clk,
    input logic                                 arst_n,
    input logic [core_types_pkg::NUM_LANES-1:0] disp_valid,
    input logic [core_types_pkg::NUM_LANES-1:0] disp_ready,
    input dispatch_pkg::result_t                result [core_types_pkg::NUM_LANES],
    input logic [core_types_pkg::NUM_LANES-1:0] result_valid,
    input logic [core_types_pkg::NUM_LANES-1:0] result_ready
);

    import core_types_pkg::*;
    import dispatch_pkg::*;

    // ====================================================================
    // Per-lane handshake rules
    // ====================================================================

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        // Stalled result must not move
        a_result_stable: assert property (@(posedge clk) disable iff (!arst_n)
            result_valid[i] && !result_ready[i] |=> $stable(result[i]))
            else $error("lane %0d result changed while stalled", i);

        // Valid is held until the outside takes it
        a_valid_held: assert property (@(posedge clk) disable iff (!arst_n)
            result_valid[i] && !result_ready[i] |=> result_valid[i])
            else $error("lane %0d result_valid dropped before acceptance", i);

        // Station full right after an accepted dispatch
        a_ready_drop: assert property (@(posedge clk) disable iff (!arst_n)
            disp_valid[i] && disp_ready[i] |=> !disp_ready[i])
            else $error("lane %0d disp_ready high after accepted dispatch", i);
    end

    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> result_valid == '0)
        else $error("result_valid high during reset");

endmodule

// ==== dv/dispatch_stage_tb.sv ====
`timescale 1ns/1ps

module dispatch_stage_tb;

    import core_types_pkg::*;
    import dispatch_pkg::*;

    localparam int MAX_REC = 64;
    localparam int TIMEOUT = 2000;     // Cycles per wait

    logic                 clk;
    logic                 arst_n;
    dispatch_req_t        disp_req [NUM_LANES];
    logic [NUM_LANES-1:0] disp_valid, disp_ready;
    result_t              result [NUM_LANES];
    logic [NUM_LANES-1:0] result_valid, result_ready;

    // Records from the stimulus file
    int      n_rec;
    int      rec_lane [MAX_REC];
    alu_op_t rec_op   [MAX_REC];
    preg_t   rec_a    [MAX_REC];
    preg_t   rec_b    [MAX_REC];
    logic    rec_ie   [MAX_REC];
    data_t   rec_imm  [MAX_REC];
    preg_t   rec_rd   [MAX_REC];
    data_t   rec_exp  [MAX_REC];       // Model value
    int      rec_hold [MAX_REC];       // Cap on result_ready low cycles
    int      lane_rec [NUM_LANES][MAX_REC];
    int      lane_cnt [NUM_LANES];
    int      seen_cnt [NUM_LANES];
    data_t   model    [64];            // Register values in dispatch order
    int      error_count;
    int      fail_count;               // Timeouts and setup problems

    dispatch_stage #(.NUM_PHYS_REGS(64)) DUT (.*);

    bind dispatch_stage dispatch_stage_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;        // 100 ns period
    end

    // ====================================================================
    // Reference rules
    // ====================================================================

    function automatic data_t compute_expected(alu_op_t op, data_t a, data_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            OP_SLL:  return a << sh;
            OP_SRL:  return a >> sh;
            OP_SRA:  return data_t'($signed(a) >>> sh);
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Parse records and build the model with the file value as a cross-check
    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] v [9];
        data_t       a, b;
        fd = $fopen("dv/dispatch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            fail_count++;
        end else begin
            while (!$feof(fd) && n_rec < MAX_REC) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                                v[3], v[4], v[5], v[6], v[7], v[8]);
                    if (n == 9) begin
                        rec_lane[n_rec] = int'(v[0]);
                        rec_op[n_rec]   = alu_op_t'(v[1]);
                        rec_a[n_rec]    = preg_t'(v[2]);
                        rec_b[n_rec]    = preg_t'(v[3]);
                        rec_ie[n_rec]   = v[4][0];
                        rec_imm[n_rec]  = v[5];
                        rec_rd[n_rec]   = preg_t'(v[6]);
                        rec_hold[n_rec] = int'(v[8]);
                        a = model[rec_a[n_rec]];
                        b = rec_ie[n_rec] ? rec_imm[n_rec] : model[rec_b[n_rec]];
                        rec_exp[n_rec] = compute_expected(rec_op[n_rec], a, b);
                        assert (rec_exp[n_rec] == v[7]) else begin
                            error_count++;
                            $display("error %0t: record %0d file value %h, model %h",
                                     $time, n_rec, v[7], rec_exp[n_rec]);
                        end
                        model[rec_rd[n_rec]] = rec_exp[n_rec];
                        lane_rec[rec_lane[n_rec]][lane_cnt[rec_lane[n_rec]]] = n_rec;
                        lane_cnt[rec_lane[n_rec]]++;
                        n_rec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ====================================================================
    // Dispatch and collection
    // ====================================================================

    task automatic dispatch_all();
        int l;
        int w;
        for (int i = 0; i < n_rec; i++) begin
            l = rec_lane[i];
            disp_req[l].op      = rec_op[i];
            disp_req[l].src_a   = rec_a[i];
            disp_req[l].src_b   = rec_b[i];
            disp_req[l].use_imm = rec_ie[i];
            disp_req[l].imm     = rec_imm[i];
            disp_req[l].rd      = rec_rd[i];
            disp_valid[l]       = 1'b1;
            w = 0;
            while (!disp_ready[l] && w < TIMEOUT) begin
                @(negedge clk);
                w++;
            end
            if (w >= TIMEOUT) begin
                $display("timeout: lane %0d never became ready for record %0d", l, i);
                fail_count++;
                disp_valid[l] = 1'b0;
                return;
            end
            @(negedge clk);            // Accepted on the edge in between
            disp_valid[l] = 1'b0;
        end
    endtask

    task automatic collect_lane(input int l);
        int          r;
        int          w;
        int          hold;
        logic [31:0] st;
        result_t     held;
        st = 32'h3401 + l;             // Own stream per lane
        for (int k = 0; k < lane_cnt[l]; k++) begin
            r = lane_rec[l][k];
            w = 0;
            while (!result_valid[l] && w < TIMEOUT) begin
                @(negedge clk);
                w++;
            end
            if (w >= TIMEOUT) begin
                $display("timeout: lane %0d gave no result for record %0d", l, r);
                fail_count++;
                return;
            end
            st   = lcg_next(st);
            hold = int'(st[23:8]) % (rec_hold[r] + 1);
            held = result[l];
            repeat (hold) begin
                @(negedge clk);
                assert (result_valid[l] && result[l] == held) else begin
                    error_count++;
                    $display("error %0t: lane %0d result moved while stalled", $time, l);
                end
            end
            assert (result[l].rd == rec_rd[r] && result[l].data == rec_exp[r]) else begin
                error_count++;
                $display("error %0t: lane %0d record %0d got rd %0d data %h, want %0d %h",
                         $time, l, r, result[l].rd, result[l].data, rec_rd[r], rec_exp[r]);
            end
            result_ready[l] = 1'b1;
            @(negedge clk);
            result_ready[l] = 1'b0;
            seen_cnt[l]++;
        end
    endtask

    // ====================================================================
    // Main sequence
    // ====================================================================

    initial begin
        arst_n       = 1'b0;
        disp_valid   = '0;
        result_ready = '0;
        error_count  = 0;
        fail_count   = 0;
        n_rec        = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            disp_req[l] = '0;
            lane_cnt[l] = 0;
            seen_cnt[l] = 0;
        end
        for (int p = 0; p < 64; p++) model[p] = '0;   // Reset state of the file
        load_stimulus();
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (disp_ready == 3'b111 && result_valid == 3'b000) else begin
            error_count++;
            $display("error %0t: handshakes wrong after reset", $time);
        end
        if (fail_count == 0) begin
            fork
                dispatch_all();
                collect_lane(0);
                collect_lane(1);
                collect_lane(2);
            join
        end
        repeat (4) @(negedge clk);
        for (int l = 0; l < NUM_LANES; l++) begin
            assert (seen_cnt[l] == lane_cnt[l] && !result_valid[l]) else begin
                error_count++;
                $display("error %0t: lane %0d retired %0d of %0d", $time, l,
                         seen_cnt[l], lane_cnt[l]);
            end
        end
        $display("records %0d, errors %0d, failures %0d", n_rec, error_count, fail_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/dispatch_stimulus.txt ====
# lane op src_a src_b use_imm imm rd expected hold, all hex
# op: 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 sltu 7 sll 8 srl 9 sra
0 0 00 00 1 00000005 01 00000005 2
1 0 00 00 1 fffffff0 02 fffffff0 0
2 0 00 00 1 00000123 03 00000123 3
0 5 02 00 1 00000001 04 00000001 1
1 6 02 00 1 00000001 05 00000000 4
2 7 01 00 1 00000004 06 00000050 0
0 8 02 00 1 00000004 07 0fffffff 2
1 9 02 00 1 00000004 08 ffffffff 5
2 2 03 00 1 000000f0 09 00000020 1
0 3 03 00 1 00001000 0a 00001123 0
1 4 03 00 1 00000fff 0b 00000edc 3
0 0 01 00 1 00000007 0c 0000000c 5
1 1 0c 06 0 00000000 0d ffffffbc 2
2 0 0d 0c 0 00000000 0e ffffffc8 4
0 4 0e 0d 0 00000000 0f 00000074 1
1 1 28 29 0 00000000 10 00000000 0
2 6 2a 2b 0 00000000 11 00000000 2
0 3 2c 2d 0 00000000 12 00000000 3
1 9 2e 2f 0 00000000 13 00000000 1
2 7 0b 01 0 00000000 14 0001db80 5
0 9 02 01 0 00000000 15 ffffffff 0
1 5 0d 0c 0 00000000 16 00000001 2
2 6 0d 0c 0 00000000 17 00000000 1
0 2 0e 08 0 00000000 18 ffffffc8 4
1 0 18 16 0 00000000 19 ffffffc9 3
2 1 19 18 0 00000000 1a 00000001 0
0 8 19 1a 0 00000000 1b 7fffffe4 2
0 0 00 00 1 00000011 1c 00000011 0
0 0 00 00 1 00000022 1d 00000022 1
0 0 00 00 1 00000033 1e 00000033 0
1 0 1c 1d 0 00000000 1f 00000033 3
2 4 1f 1e 0 00000000 20 00000000 2
1 3 1b 20 0 00000000 21 7fffffe4 1
2 7 1b 00 1 00000001 22 ffffffc8 0

// ==== files.f ====
rtl/core_types_pkg.sv
rtl/dispatch_pkg.sv
rtl/phys_reg_file.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/cdb_result_stage.sv
rtl/dispatch_stage.sv
dv/dispatch_stage_checker.sv
dv/dispatch_stage_tb.sv

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  dispatch_pkg::exec_req_t exec_req,
    input  logic                    exec_valid,
    output logic                    exec_ready,
    output dispatch_pkg::result_t   alu_res,
    output logic                    alu_valid,
    input  logic                    alu_ready
);

    import core_types_pkg::*;
    import dispatch_pkg::*;

    data_t      calc;          // Combinational result
    logic [4:0] shamt;         // RV32I shift amount
    logic       valid_q;       // Output register occupied
    result_t    res_q;

    assign shamt = exec_req.b[4:0];

    // ====================================================================
    // Operation
    // ====================================================================

    always_comb begin
        case (exec_req.op)
            OP_ADD:  calc = exec_req.a + exec_req.b;
            OP_SUB:  calc = exec_req.a - exec_req.b;
            OP_AND:  calc = exec_req.a & exec_req.b;
            OP_OR:   calc = exec_req.a | exec_req.b;
            OP_XOR:  calc = exec_req.a ^ exec_req.b;
            OP_SLT:  calc = data_t'($signed(exec_req.a) < $signed(exec_req.b));
            OP_SLTU: calc = data_t'(exec_req.a < exec_req.b);
            OP_SLL:  calc = exec_req.a << shamt;
            OP_SRL:  calc = exec_req.a >> shamt;
            OP_SRA:  calc = data_t'($signed(exec_req.a) >>> shamt);
            default: calc = '0;                // Unused codes give zero
        endcase
    end

    // ====================================================================
    // Output register
    // ====================================================================

    // Take a new request when empty or draining this cycle
    assign exec_ready = !valid_q || alu_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (exec_ready) begin
            valid_q <= exec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_valid && exec_ready) begin
            res_q.rd   <= exec_req.rd;
            res_q.data <= calc;
        end
    end

    assign alu_res   = res_q;
    assign alu_valid = valid_q;

endmodule

// ==== rtl/cdb_result_stage.sv ====
`timescale 1ns/1ps

module cdb_result_stage (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  dispatch_pkg::result_t                alu_res [core_types_pkg::NUM_LANES],
    input  logic [core_types_pkg::NUM_LANES-1:0] alu_valid,
    output logic [core_types_pkg::NUM_LANES-1:0] alu_ready,
    output dispatch_pkg::result_t                result [core_types_pkg::NUM_LANES],
    output logic [core_types_pkg::NUM_LANES-1:0] result_valid,
    input  logic [core_types_pkg::NUM_LANES-1:0] result_ready,
    output dispatch_pkg::cdb_t                   cdb [core_types_pkg::NUM_LANES]
);

    import core_types_pkg::*;
    import dispatch_pkg::*;

    logic [NUM_LANES-1:0] valid_q;     // Result register occupied
    result_t              res_q [NUM_LANES];

    // Free or being accepted this cycle
    assign alu_ready = ~valid_q | result_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (alu_ready[l]) valid_q[l] <= alu_valid[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (alu_valid[l] && alu_ready[l]) res_q[l] <= alu_res[l];
        end
    end

    // ====================================================================
    // Hand-off and broadcast
    // ====================================================================

    // Broadcast only in the accepting cycle, so wake-ups see retired results
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            result[l]     = res_q[l];
            cdb[l].valid  = valid_q[l] && result_ready[l];
            cdb[l].rd     = res_q[l].rd;
            cdb[l].data   = res_q[l].data;
        end
    end

    assign result_valid = valid_q;

endmodule

// ==== rtl/core_types_pkg.sv ====
package core_types_pkg;

    // ====================================================================
    // Core widths
    // ====================================================================

    localparam int NUM_LANES  = 3;      // Dispatch lanes with one ALU each
    localparam int DATA_WIDTH = 32;     // RV32I datapath
    localparam int PREG_WIDTH = 6;      // Up to 64 physical registers

    typedef logic [DATA_WIDTH-1:0] data_t;    // Operand or result value
    typedef logic [PREG_WIDTH-1:0] preg_t;    // Physical register number
    typedef logic [1:0]            tag_t;     // Producing lane, 0 to 2

    // Value present in the register with no producer outstanding
    localparam tag_t TAG_READY = 2'd3;

    // ====================================================================
    // ALU operation codes
    // ====================================================================

    typedef logic [3:0] alu_op_t;

    localparam alu_op_t OP_ADD  = 4'd0;
    localparam alu_op_t OP_SUB  = 4'd1;
    localparam alu_op_t OP_AND  = 4'd2;
    localparam alu_op_t OP_OR   = 4'd3;
    localparam alu_op_t OP_XOR  = 4'd4;
    localparam alu_op_t OP_SLT  = 4'd5;    // Signed compare
    localparam alu_op_t OP_SLTU = 4'd6;    // Unsigned compare
    localparam alu_op_t OP_SLL  = 4'd7;
    localparam alu_op_t OP_SRL  = 4'd8;
    localparam alu_op_t OP_SRA  = 4'd9;    // Sign-filling right shift

endpackage

// ==== rtl/dispatch_pkg.sv ====
package dispatch_pkg;

    import core_types_pkg::*;

    // Renamed instruction from the issue side
    typedef struct packed {
        alu_op_t op;
        preg_t   src_a;
        preg_t   src_b;
        logic    use_imm;     // Immediate replaces src_b
        data_t   imm;
        preg_t   rd;
    } dispatch_req_t;

    // Operand value plus producer tag
    typedef struct packed {
        data_t value;         // Only meaningful once tag is TAG_READY
        tag_t  tag;
    } operand_t;

    // Station contents after decode
    typedef struct packed {
        alu_op_t  op;
        operand_t a;
        operand_t b;
        preg_t    rd;
    } rs_entry_t;

    // Issued to the ALU, both operands resolved
    typedef struct packed {
        alu_op_t op;
        data_t   a;
        data_t   b;
        preg_t   rd;
    } exec_req_t;

    typedef struct packed {
        preg_t rd;
        data_t data;
    } result_t;

    // One broadcast channel per producing lane
    typedef struct packed {
        logic  valid;
        preg_t rd;
        data_t data;
    } cdb_t;

    typedef enum logic [1:0] {
        RS_EMPTY,             // Free for dispatch
        RS_WAIT,              // Snooping for missing operands
        RS_ISSUED             // Offered to the ALU
    } rs_state_t;

endpackage

// ==== rtl/dispatch_stage.sv ====
`timescale 1ns/1ps

module dispatch_stage #(
    parameter int NUM_PHYS_REGS = 64
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  dispatch_pkg::dispatch_req_t          disp_req [core_types_pkg::NUM_LANES],
    input  logic [core_types_pkg::NUM_LANES-1:0] disp_valid,
    output logic [core_types_pkg::NUM_LANES-1:0] disp_ready,
    output dispatch_pkg::result_t                result [core_types_pkg::NUM_LANES],
    output logic [core_types_pkg::NUM_LANES-1:0] result_valid,
    input  logic [core_types_pkg::NUM_LANES-1:0] result_ready
);

    import core_types_pkg::*;
    import dispatch_pkg::*;

    preg_t                rd_addr  [2*NUM_LANES];  // Lane i uses ports 2i and 2i+1
    operand_t             rd_opnd  [2*NUM_LANES];
    logic [NUM_LANES-1:0] alloc_en;
    preg_t                alloc_rd [NUM_LANES];
    cdb_t                 cdb      [NUM_LANES];
    exec_req_t            exec_req [NUM_LANES];
    logic [NUM_LANES-1:0] exec_valid, exec_ready;
    result_t              alu_res  [NUM_LANES];
    logic [NUM_LANES-1:0] alu_valid, alu_ready;

    // ====================================================================
    // Shared register file
    // ====================================================================

    phys_reg_file #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) u_prf (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_addr  (rd_addr),
        .rd_opnd  (rd_opnd),
        .alloc_en (alloc_en),
        .alloc_rd (alloc_rd),
        .cdb      (cdb)
    );

    // ====================================================================
    // Lanes
    // ====================================================================

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        preg_t    src_addr [2];
        operand_t src_opnd [2];

        assign rd_addr[2*i]   = src_addr[0];
        assign rd_addr[2*i+1] = src_addr[1];
        assign src_opnd[0]    = rd_opnd[2*i];
        assign src_opnd[1]    = rd_opnd[2*i+1];

        // Tag rd on the accepting edge
        assign alloc_en[i] = disp_valid[i] & disp_ready[i];
        assign alloc_rd[i] = disp_req[i].rd;

        reservation_station #(
            .LANE_TAG (tag_t'(i))
        ) u_rs (
            .clk        (clk),
            .arst_n     (arst_n),
            .disp_req   (disp_req[i]),
            .disp_valid (disp_valid[i]),
            .disp_ready (disp_ready[i]),
            .src_addr   (src_addr),
            .src_opnd   (src_opnd),
            .cdb        (cdb),
            .exec_req   (exec_req[i]),
            .exec_valid (exec_valid[i]),
            .exec_ready (exec_ready[i])
        );

        alu_unit u_alu (
            .clk        (clk),
            .arst_n     (arst_n),
            .exec_req   (exec_req[i]),
            .exec_valid (exec_valid[i]),
            .exec_ready (exec_ready[i]),
            .alu_res    (alu_res[i]),
            .alu_valid  (alu_valid[i]),
            .alu_ready  (alu_ready[i])
        );
    end

    // Result hand-off driving all three CDB channels
    cdb_result_stage u_cdb (
        .clk          (clk),
        .arst_n       (arst_n),
        .alu_res      (alu_res),
        .alu_valid    (alu_valid),
        .alu_ready    (alu_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .cdb          (cdb)
    );

endmodule

// ==== rtl/phys_reg_file.sv ====
`timescale 1ns/1ps

module phys_reg_file #(
    parameter int NUM_PHYS_REGS = 64
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  core_types_pkg::preg_t                rd_addr [2*core_types_pkg::NUM_LANES],
    output dispatch_pkg::operand_t               rd_opnd [2*core_types_pkg::NUM_LANES],
    input  logic [core_types_pkg::NUM_LANES-1:0] alloc_en,
    input  core_types_pkg::preg_t                alloc_rd [core_types_pkg::NUM_LANES],
    input  dispatch_pkg::cdb_t                   cdb [core_types_pkg::NUM_LANES]
);

    import core_types_pkg::*;
    import dispatch_pkg::*;

    localparam int NUM_RD = 2 * NUM_LANES;     // Two sources per lane

    data_t value_q [NUM_PHYS_REGS];
    tag_t  tag_q   [NUM_PHYS_REGS];            // TAG_READY or producing lane

    // ====================================================================
    // Read ports
    // ====================================================================

    // Stored value and tag, or CDB data when the producer retires this cycle
    always_comb begin
        tag_t  cur_tag;
        preg_t addr;
        cur_tag = TAG_READY;
        addr    = '0;
        for (int r = 0; r < NUM_RD; r++) begin
            addr              = rd_addr[r];
            cur_tag           = tag_q[addr];
            rd_opnd[r].value  = value_q[addr];
            rd_opnd[r].tag    = cur_tag;
            if (cur_tag != TAG_READY) begin
                // Producer channel index equals the tag
                if (cdb[cur_tag].valid && cdb[cur_tag].rd == addr) begin
                    rd_opnd[r].value = cdb[cur_tag].data;     // Bypass
                    rd_opnd[r].tag   = TAG_READY;
                end
            end
        end
    end

    // ====================================================================
    // Commit and allocation
    // ====================================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < NUM_PHYS_REGS; p++) begin
                value_q[p] <= '0;
                tag_q[p]   <= TAG_READY;              // All registers present
            end
        end else begin
            // Commit only if this lane is still the recorded producer
            for (int l = 0; l < NUM_LANES; l++) begin
                if (cdb[l].valid && tag_q[cdb[l].rd] == tag_t'(l)) begin
                    value_q[cdb[l].rd] <= cdb[l].data;
                    tag_q[cdb[l].rd]   <= TAG_READY;
                end
            end
            // Later assignment, so allocation beats a same-cycle commit
            for (int l = 0; l < NUM_LANES; l++) begin
                if (alloc_en[l]) begin
                    tag_q[alloc_rd[l]] <= tag_t'(l);  // Pending on lane l
                end
            end
        end
    end

endmodule

// ==== rtl/reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station #(
    parameter core_types_pkg::tag_t LANE_TAG = 2'd0
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  dispatch_pkg::dispatch_req_t disp_req,
    input  logic                        disp_valid,
    output logic                        disp_ready,
    output core_types_pkg::preg_t       src_addr [2],
    input  dispatch_pkg::operand_t      src_opnd [2],
    input  dispatch_pkg::cdb_t          cdb [core_types_pkg::NUM_LANES],
    output dispatch_pkg::exec_req_t     exec_req,
    output logic                        exec_valid,
    input  logic                        exec_ready
);

    import core_types_pkg::*;
    import dispatch_pkg::*;

    rs_state_t state_q, state_d;
    rs_entry_t entry_q;            // Held instruction
    preg_t     src_q [2];          // Source numbers for the CDB compare
    rs_entry_t dec_entry;          // Decoded from the dispatch request
    operand_t  a_snp, b_snp;       // Held operands after this cycle's CDB
    logic      accept;

    // Pick the channel named by the tag and capture on an rd match
    function automatic operand_t snoop(operand_t opnd, preg_t src);
        operand_t res;
        cdb_t     bus;
        res = opnd;
        bus = '0;
        if (opnd.tag != TAG_READY) begin
            bus = cdb[opnd.tag];               // Channel index equals the tag
        end
        if (bus.valid && bus.rd == src) begin
            res.value = bus.data;
            res.tag   = TAG_READY;
        end
        return res;
    endfunction

    // ====================================================================
    // Decode
    // ====================================================================

    assign disp_ready  = (state_q == RS_EMPTY);
    assign accept      = disp_valid && disp_ready;
    assign src_addr[0] = disp_req.src_a;       // Register file read in the same cycle
    assign src_addr[1] = disp_req.src_b;

    always_comb begin
        dec_entry.op = disp_req.op;
        dec_entry.a  = src_opnd[0];
        dec_entry.b  = src_opnd[1];
        dec_entry.rd = disp_req.rd;
        if (disp_req.use_imm) begin
            dec_entry.b.value = disp_req.imm;  // Immediate always present
            dec_entry.b.tag   = TAG_READY;
        end
    end

    always_comb begin
        a_snp = snoop(entry_q.a, src_q[0]);
        b_snp = snoop(entry_q.b, src_q[1]);
    end

    // ====================================================================
    // State machine
    // ====================================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            RS_EMPTY: begin
                if (accept) begin
                    if (dec_entry.a.tag == TAG_READY && dec_entry.b.tag == TAG_READY) begin
                        state_d = RS_ISSUED;
                    end else begin
                        state_d = RS_WAIT;
                    end
                end
            end
            RS_WAIT: begin
                if (a_snp.tag == TAG_READY && b_snp.tag == TAG_READY) begin
                    state_d = RS_ISSUED;       // Issue the cycle after wake-up
                end
            end
            RS_ISSUED: begin
                if (exec_ready) state_d = RS_EMPTY;
            end
            default: state_d = RS_EMPTY;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) state_q <= RS_EMPTY;
        else         state_q <= state_d;
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (accept) begin
            entry_q  <= dec_entry;
            src_q[0] <= disp_req.src_a;
            src_q[1] <= disp_req.src_b;
        end else if (state_q == RS_WAIT) begin
            entry_q.a <= a_snp;                // Keep captured CDB values
            entry_q.b <= b_snp;
        end
    end

    // ====================================================================
    // Issue
    // ====================================================================

    assign exec_valid = (state_q == RS_ISSUED);

    always_comb begin
        exec_req.op = entry_q.op;
        exec_req.a  = entry_q.a.value;
        exec_req.b  = entry_q.b.value;
        exec_req.rd = entry_q.rd;
    end

endmodule
